/* list.f */
source/pkt_chk_pkg.sv
source/pkt_chk_ctrl.sv
source/beat_assembler.sv
source/expected_store.sv
source/pkt_matcher.sv
source/pkt_chk_top.sv
sim/tb_pkt_chk.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the packet checker testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f list.f --top-module tb_pkt_chk \
    --Mdir "$build_dir" -o tb_pkt_chk
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$build_dir/tb_pkt_chk" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "CHECKS FAILED" "$log_file"; then
    exit 1
fi
exit 0

/* sim/tb_pkt_chk.sv */
// ####################
// packet checker testbench with bus and stream drivers and a scoreboard model
// ####################
`timescale 1ns/10ps

module tb_pkt_chk;

    localparam int wait_limit = 64;

    logic                       axis_packet_in;
    logic                       rst;
    pkt_chk_pkg::wb_req_t       wb_req;
    pkt_chk_pkg::wb_rsp_t       wb_rsp;
    logic                       s_tvalid;
    pkt_chk_pkg::axis_beat_t    s_beat;
    logic                       s_tready;
    logic                       chk_error;

    logic [31:0]  lfsr_q;
    logic [31:0]  exp_rd;
    logic         rd_check;
    logic         err_check;
    logic         aborted;
    int           value_errs;
    int           timeouts;
    int           order [pkt_chk_pkg::num_slots];

    // scoreboard model of the slots and the status word
    logic [pkt_chk_pkg::num_slots-1:0]  exp_valid;
    logic [pkt_chk_pkg::blen_w-1:0]     exp_blen [pkt_chk_pkg::num_slots];
    logic [127:0]                       exp_bytes [pkt_chk_pkg::num_slots];
    logic [pkt_chk_pkg::num_slots-1:0]  exp_claimed;
    logic [7:0]                         exp_hits;
    logic [7:0]                         exp_misses;
    logic                               exp_err;

    pkt_chk_top UUT (
        .axis_packet_in (axis_packet_in),
        .rst            (rst),
        .wb_req         (wb_req),
        .s_tvalid       (s_tvalid),
        .s_beat         (s_beat),
        .wb_rsp         (wb_rsp),
        .s_tready       (s_tready),
        .chk_error      (chk_error)
    );

    initial begin
        axis_packet_in = 1'b0;
        forever #50 axis_packet_in = ~axis_packet_in;
    end

    ack_one_cycle: assert property (@(posedge axis_packet_in) disable iff (rst)
        wb_rsp.ack |=> !wb_rsp.ack)
        else begin
            value_errs++;
            $display("[FAIL] %0t wb_rsp.ack expected 0 got 1", $time);
        end

    ack_after_strobe: assert property (@(posedge axis_packet_in) disable iff (rst)
        ($rose(wb_req.stb) && wb_req.cyc) |=> wb_rsp.ack)
        else begin
            value_errs++;
            $display("[FAIL] %0t wb_rsp.ack expected 1 got 0", $time);
        end

    read_data_match: assert property (@(posedge axis_packet_in) disable iff (rst)
        (wb_rsp.ack && rd_check) |-> (wb_rsp.dat == exp_rd))
        else begin
            value_errs++;
            $display("[FAIL] %0t wb_rsp.dat expected %h got %h", $time, exp_rd, wb_rsp.dat);
        end

    error_flag_match: assert property (@(posedge axis_packet_in) disable iff (rst)
        err_check |-> (chk_error == exp_err))
        else begin
            value_errs++;
            $display("[FAIL] %0t chk_error expected %0b got %0b", $time, exp_err, chk_error);
        end

    tready_drops_after_last: assert property (@(posedge axis_packet_in) disable iff (rst)
        (s_tvalid && s_tready && s_beat.tlast) |=> !s_tready)
        else begin
            value_errs++;
            $display("[FAIL] %0t s_tready expected 0 got 1", $time);
        end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    function automatic logic [127:0] rand_bytes();
        logic [127:0] v;
        v = '0;
        for (int w = 0; w < 4; w++) begin
            v[w*32 +: 32] = rand_bits(32);
        end
        return v;
    endfunction

    function automatic logic [3:0] keep_mask(input int n);
        return 4'((1 << n) - 1);
    endfunction

    function automatic logic [5:0] slot_adr(input int s, input int ofs);
        return pkt_chk_pkg::adr_slot_base + 6'(8 * s + ofs);
    endfunction

    // first valid unclaimed slot with equal length and bytes wins
    function automatic void model_packet(input logic [159:0] data, input int nbeats,
                                         input logic [3:0] last_keep);
        int   blen;
        int   hit_slot;
        logic same;
        blen = 4 * (nbeats - 1) + $countones(last_keep);
        hit_slot = -1;
        for (int s = 0; s < pkt_chk_pkg::num_slots; s++) begin
            same = 1'b1;
            for (int b = 0; b < blen && b < 16; b++) begin
                if (data[b*8 +: 8] != exp_bytes[s][b*8 +: 8]) begin
                    same = 1'b0;
                end
            end
            if (hit_slot < 0 && nbeats <= 4 && exp_valid[s] && !exp_claimed[s] &&
                int'(exp_blen[s]) == blen && same) begin
                hit_slot = s;
            end
        end
        if (hit_slot >= 0) begin
            exp_hits++;
            exp_claimed[hit_slot] = 1'b1;
        end else begin
            exp_misses++;
            exp_err = 1'b1;
        end
    endfunction

    function automatic void clear_model_counts();
        exp_hits    = '0;
        exp_misses  = '0;
        exp_claimed = '0;
        exp_err     = 1'b0;
    endfunction

    task automatic report_timeout(input string what);
        $display("timeout after %0d cycles waiting for %s at %0t", wait_limit, what, $time);
        timeouts++;
        aborted = 1'b1;
    endtask

    task automatic bus_cycle(input logic we, input logic [5:0] adr, input logic [31:0] dat);
        int n;
        if (aborted) return;
        err_check = 1'b0;
        @(posedge axis_packet_in);
        wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: dat};
        n = 0;
        @(negedge axis_packet_in);
        while (!wb_rsp.ack && n < wait_limit) begin
            @(negedge axis_packet_in);
            n++;
        end
        if (!wb_rsp.ack) report_timeout("the wishbone ack");
        @(posedge axis_packet_in);
        wb_req.cyc <= 1'b0;
        wb_req.stb <= 1'b0;
        wb_req.we  <= 1'b0;
        @(negedge axis_packet_in);
    endtask

    task automatic bus_write(input logic [5:0] adr, input logic [31:0] dat);
        bus_cycle(1'b1, adr, dat);
    endtask

    task automatic bus_read(input logic [5:0] adr, input logic [31:0] expected);
        exp_rd   = expected;
        rd_check = 1'b1;
        bus_cycle(1'b0, adr, '0);
        rd_check = 1'b0;
    endtask

    task automatic check_status();
        bus_read(pkt_chk_pkg::adr_status,
                 {7'd0, exp_err, 4'd0, exp_claimed, exp_misses, exp_hits});
        // chk_error is watched until the next bus access or packet
        if (!aborted) err_check = 1'b1;
    endtask

    task automatic load_slot(input int s, input logic [4:0] blen, input logic [127:0] bytes);
        pkt_chk_pkg::wb_word_u w;
        w.raw        = '0;
        w.desc.blen  = blen;
        w.desc.valid = 1'b1;
        exp_valid[s] = 1'b1;
        exp_blen[s]  = blen;
        exp_bytes[s] = bytes;
        bus_write(slot_adr(s, 0), w.raw);
        for (int k = 0; k < 4; k++) begin
            bus_write(slot_adr(s, k + 1), bytes[k*32 +: 32]);
        end
    endtask

    task automatic verify_slot(input int s);
        pkt_chk_pkg::wb_word_u w;
        w.raw        = '0;
        w.desc.blen  = exp_blen[s];
        w.desc.valid = exp_valid[s];
        bus_read(slot_adr(s, 0), w.raw);
        for (int k = 0; k < 4; k++) begin
            bus_read(slot_adr(s, k + 1), exp_bytes[s][k*32 +: 32]);
        end
    endtask

    // returns on the tlast transfer edge, so a following call meets back-pressure
    task automatic send_packet(input logic [159:0] data, input int nbeats,
                               input logic [3:0] last_keep);
        int n;
        if (aborted) return;
        for (int i = 0; i < nbeats; i++) begin
            @(posedge axis_packet_in);
            s_tvalid <= 1'b1;
            s_beat   <= '{tdata: data[i*32 +: 32],
                          tkeep: (i == nbeats - 1) ? last_keep : 4'hf,
                          tlast: (i == nbeats - 1)};
            n = 0;
            @(negedge axis_packet_in);
            while (!s_tready && n < wait_limit) begin
                @(negedge axis_packet_in);
                n++;
            end
            if (!s_tready) begin
                report_timeout("s_tready during a packet");
                return;
            end
        end
        @(posedge axis_packet_in);
        s_tvalid <= 1'b0;
    endtask

    task automatic send_modeled(input logic [159:0] data, input int nbeats,
                                input logic [3:0] last_keep);
        err_check = 1'b0;
        model_packet(data, nbeats, last_keep);
        send_packet(data, nbeats, last_keep);
    endtask

    task automatic send_bytes(input logic [159:0] data, input int blen);
        int nbeats;
        nbeats = (blen + 3) / 4;
        send_modeled(data, nbeats, keep_mask(blen - 4 * (nbeats - 1)));
    endtask

    task automatic send_slot_packet(input int s);
        send_bytes({32'd0, exp_bytes[s]}, int'(exp_blen[s]));
    endtask

    // counters settle on the same edge that releases tready
    task automatic wait_result();
        int n;
        if (aborted) return;
        n = 0;
        @(negedge axis_packet_in);
        while (!s_tready && n < wait_limit) begin
            @(negedge axis_packet_in);
            n++;
        end
        if (!s_tready) report_timeout("the match result to release s_tready");
    endtask

    initial begin
        int           j;
        int           tmp;
        logic [159:0] data;
        lfsr_q      = 32'hd5c6_b490;
        rst         = 1'b1;
        wb_req      = '0;
        s_tvalid    = 1'b0;
        s_beat      = '0;
        exp_rd      = '0;
        rd_check    = 1'b0;
        err_check   = 1'b0;
        aborted     = 1'b0;
        value_errs  = 0;
        timeouts    = 0;
        exp_valid   = '0;
        clear_model_counts();
        for (int s = 0; s < pkt_chk_pkg::num_slots; s++) begin
            exp_blen[s]  = '0;
            exp_bytes[s] = '0;
            order[s]     = s;
        end
        repeat (10) @(posedge axis_packet_in);
        rst <= 1'b0;
        @(negedge axis_packet_in);

        // bus readback of every slot
        check_status();
        for (int s = 0; s < pkt_chk_pkg::num_slots; s++) begin
            load_slot(s, 5'(rand_bits(4) + 1), rand_bytes());
            verify_slot(s);
        end

        // all four packets in a shuffled order
        for (int i = pkt_chk_pkg::num_slots - 1; i > 0; i--) begin
            j = int'(rand_bits(2)) % (i + 1);
            tmp = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        for (int i = 0; i < pkt_chk_pkg::num_slots; i++) begin
            send_slot_packet(order[i]);
            wait_result();
            check_status();
        end

        // repeat of a claimed packet
        send_slot_packet(order[0]);
        wait_result();
        check_status();

        // counter clear, then wrong bytes and one byte short against the exact length
        bus_write(pkt_chk_pkg::adr_ctrl, 32'h1);
        clear_model_counts();
        check_status();
        load_slot(0, 5'd7, rand_bytes());
        send_bytes({32'd0, rand_bytes()}, 7);
        wait_result();
        check_status();
        send_modeled({32'd0, exp_bytes[0]}, 2, 4'b0011);
        wait_result();
        check_status();
        send_bytes({32'd0, exp_bytes[0]}, 7);
        wait_result();
        check_status();

        // oversize packet against a full-length slot and the next one held under back-pressure
        bus_write(pkt_chk_pkg::adr_ctrl, 32'h1);
        clear_model_counts();
        load_slot(1, 5'd16, rand_bytes());
        data = {rand_bits(32), exp_bytes[1]};
        send_modeled(data, 5, 4'hf);
        send_slot_packet(1);
        wait_result();
        check_status();

        // invalidate every slot
        bus_write(pkt_chk_pkg::adr_ctrl, 32'h2);
        exp_valid = '0;
        verify_slot(2);
        send_slot_packet(2);
        wait_result();
        check_status();

        err_check = 1'b0;
        repeat (2) @(negedge axis_packet_in);
        $display("errors: %0d value mismatches, %0d timeouts", value_errs, timeouts);
        if (value_errs == 0 && timeouts == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* source/pkt_chk_top.sv */
// ####################
// packet checker top, control plus the stream datapath
// ####################
`timescale 1ns/10ps

module pkt_chk_top (
    input  logic                        axis_packet_in,
    input  logic                        rst,
    input  pkt_chk_pkg::wb_req_t        wb_req,
    input  logic                        s_tvalid,
    input  pkt_chk_pkg::axis_beat_t     s_beat,
    output pkt_chk_pkg::wb_rsp_t        wb_rsp,
    output logic                        s_tready,
    output logic                        chk_error
);

    pkt_chk_pkg::match_result_t             result;
    pkt_chk_pkg::wb_word_u                  store_rd_data;
    pkt_chk_pkg::store_wr_t                 store_wr;
    logic                                   store_clear;
    logic [pkt_chk_pkg::slot_w-1:0]         rd_slot;
    logic [pkt_chk_pkg::ofs_w-1:0]          rd_ofs;
    logic [pkt_chk_pkg::num_slots-1:0]      claimed;
    logic                                   pkt_valid;
    pkt_chk_pkg::rx_pkt_t                   pkt;
    logic [pkt_chk_pkg::slot_w-1:0]         cmp_slot;
    pkt_chk_pkg::slot_desc_t                cmp_desc;
    logic [pkt_chk_pkg::mtu_bytes*8-1:0]    cmp_bytes;

    pkt_chk_ctrl u_ctrl (
        .axis_packet_in (axis_packet_in),
        .rst            (rst),
        .wb_req         (wb_req),
        .result         (result),
        .store_rd_data  (store_rd_data),
        .wb_rsp         (wb_rsp),
        .store_wr       (store_wr),
        .store_clear    (store_clear),
        .store_rd_slot  (rd_slot),
        .store_rd_ofs   (rd_ofs),
        .claimed        (claimed),
        .chk_error      (chk_error)
    );

    beat_assembler u_assembler (
        .axis_packet_in (axis_packet_in),
        .rst            (rst),
        .s_tvalid       (s_tvalid),
        .s_beat         (s_beat),
        .done           (result.done),
        .s_tready       (s_tready),
        .pkt_valid      (pkt_valid),
        .pkt            (pkt)
    );

    expected_store u_store (
        .axis_packet_in (axis_packet_in),
        .rst            (rst),
        .store_wr       (store_wr),
        .store_clear    (store_clear),
        .rd_slot        (rd_slot),
        .rd_ofs         (rd_ofs),
        .cmp_slot       (cmp_slot),
        .rd_data        (store_rd_data),
        .cmp_desc       (cmp_desc),
        .cmp_bytes      (cmp_bytes)
    );

    pkt_matcher u_matcher (
        .axis_packet_in (axis_packet_in),
        .rst            (rst),
        .pkt_valid      (pkt_valid),
        .pkt            (pkt),
        .claimed        (claimed),
        .cmp_desc       (cmp_desc),
        .cmp_bytes      (cmp_bytes),
        .cmp_slot       (cmp_slot),
        .result         (result)
    );

endmodule

/* source/pkt_matcher.sv */
// ####################
// walks the expected slots one per cycle looking for a match
// ####################
`timescale 1ns/10ps

module pkt_matcher (
    input  logic                                axis_packet_in,
    input  logic                                rst,
    input  logic                                pkt_valid,
    input  pkt_chk_pkg::rx_pkt_t                pkt,
    input  logic [pkt_chk_pkg::num_slots-1:0]   claimed,
    input  pkt_chk_pkg::slot_desc_t             cmp_desc,
    input  logic [pkt_chk_pkg::mtu_bytes*8-1:0] cmp_bytes,
    output logic [pkt_chk_pkg::slot_w-1:0]      cmp_slot,
    output pkt_chk_pkg::match_result_t          result
);

    logic                               busy;
    logic [pkt_chk_pkg::slot_w-1:0]     idx;
    logic                               last_slot;
    logic                               bytes_eq;
    logic                               slot_hit;
    logic                               done_q;
    logic                               hit_q;
    logic [pkt_chk_pkg::slot_w-1:0]     slot_q;

    // only bytes below the packet length take part
    always_comb begin
        bytes_eq = 1'b1;
        for (int b = 0; b < pkt_chk_pkg::mtu_bytes; b++) begin
            if (b < pkt.blen && pkt.bytes[b*8 +: 8] != cmp_bytes[b*8 +: 8]) begin
                bytes_eq = 1'b0;
            end
        end
    end

    assign slot_hit  = cmp_desc.valid && !claimed[idx] && !pkt.oversize &&
                       (cmp_desc.blen == pkt.blen) && bytes_eq;
    assign last_slot = idx == pkt_chk_pkg::slot_w'(pkt_chk_pkg::num_slots - 1);
    assign cmp_slot  = idx;

    always_ff @(posedge axis_packet_in) begin
        if (rst) begin
            busy   <= 1'b0;
            idx    <= '0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (pkt_valid) begin
                busy <= 1'b1;
                idx  <= '0;
            end else if (busy) begin
                // stop on the first hit, or give up after the last slot
                if (slot_hit || last_slot) begin
                    busy   <= 1'b0;
                    done_q <= 1'b1;
                end else begin
                    idx <= idx + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge axis_packet_in) begin
        if (busy) begin
            hit_q  <= slot_hit;
            slot_q <= idx;
        end
    end

    assign result.done = done_q;
    assign result.hit  = hit_q;
    assign result.slot = slot_q;

    no_packet_during_search: assert property (@(posedge axis_packet_in) disable iff (rst)
        pkt_valid |-> !busy);

endmodule

/* source/expected_store.sv */
// ####################
// expected packet slots, host access and whole-slot compare port
// ####################
`timescale 1ns/10ps

module expected_store (
    input  logic                                axis_packet_in,
    input  logic                                rst,
    input  pkt_chk_pkg::store_wr_t              store_wr,
    input  logic                                store_clear,
    input  logic [pkt_chk_pkg::slot_w-1:0]      rd_slot,
    input  logic [pkt_chk_pkg::ofs_w-1:0]       rd_ofs,
    input  logic [pkt_chk_pkg::slot_w-1:0]      cmp_slot,
    output pkt_chk_pkg::wb_word_u               rd_data,
    output pkt_chk_pkg::slot_desc_t             cmp_desc,
    output logic [pkt_chk_pkg::mtu_bytes*8-1:0] cmp_bytes
);

    logic [pkt_chk_pkg::num_slots-1:0]  valid_q;
    logic [pkt_chk_pkg::blen_w-1:0]     blen_q [pkt_chk_pkg::num_slots];
    logic [31:0]                        data_q [pkt_chk_pkg::num_slots][pkt_chk_pkg::mtu_words];
    logic [pkt_chk_pkg::word_w-1:0]     wr_word;
    logic [pkt_chk_pkg::word_w-1:0]     rd_word;

    // data words sit at offsets 1 to mtu_words
    assign wr_word = pkt_chk_pkg::word_w'(store_wr.ofs - 3'd1);
    assign rd_word = pkt_chk_pkg::word_w'(rd_ofs - 3'd1);

    always_ff @(posedge axis_packet_in) begin
        if (rst) begin
            valid_q <= '0;
        end else if (store_clear) begin
            valid_q <= '0;
        end else if (store_wr.we && store_wr.ofs == '0) begin
            valid_q[store_wr.slot] <= store_wr.word.desc.valid;
        end
    end

    always_ff @(posedge axis_packet_in) begin
        if (store_wr.we && store_wr.ofs == '0) begin
            blen_q[store_wr.slot] <= store_wr.word.desc.blen;
        end else if (store_wr.we && store_wr.ofs <= pkt_chk_pkg::mtu_words) begin
            data_q[store_wr.slot][wr_word] <= store_wr.word.raw;
        end
    end

    always_comb begin
        rd_data.raw = '0;
        if (rd_ofs == '0) begin
            rd_data.desc = '{rsvd: '0, blen: blen_q[rd_slot], valid: valid_q[rd_slot]};
        end else if (rd_ofs <= pkt_chk_pkg::mtu_words) begin
            rd_data.raw = data_q[rd_slot][rd_word];
        end
    end

    assign cmp_desc = '{rsvd: '0, blen: blen_q[cmp_slot], valid: valid_q[cmp_slot]};

    always_comb begin
        for (int w = 0; w < pkt_chk_pkg::mtu_words; w++) begin
            cmp_bytes[w*32 +: 32] = data_q[cmp_slot][w];
        end
    end

endmodule

/* source/beat_assembler.sv */
// ####################
// axi-stream sink that builds one packet vector and its byte length
// ####################
`timescale 1ns/10ps

module beat_assembler (
    input  logic                        axis_packet_in,
    input  logic                        rst,
    input  logic                        s_tvalid,
    input  pkt_chk_pkg::axis_beat_t     s_beat,
    input  logic                        done,
    output logic                        s_tready,
    output logic                        pkt_valid,
    output pkt_chk_pkg::rx_pkt_t        pkt
);

    logic                                       xfer;
    logic                                       in_range;
    logic                                       wait_q;
    logic                                       valid_q;
    logic                                       ovf;
    logic [pkt_chk_pkg::ptr_w-1:0]              ptr;
    logic [pkt_chk_pkg::blen_w-1:0]             cnt;
    logic [pkt_chk_pkg::blen_w-1:0]             last_bytes;
    logic [pkt_chk_pkg::mtu_bytes*8-1:0]        pkt_bytes;
    logic [pkt_chk_pkg::blen_w-1:0]             pkt_blen;
    logic                                       pkt_ovf;

    assign xfer       = s_tvalid && s_tready;
    assign in_range   = ptr < pkt_chk_pkg::ptr_w'(pkt_chk_pkg::mtu_words);
    assign last_bytes = pkt_chk_pkg::blen_w'($countones(s_beat.tkeep));
    // held low from the tlast beat until the matcher is done
    assign s_tready   = !wait_q;

    always_ff @(posedge axis_packet_in) begin
        if (rst) begin
            wait_q  <= 1'b0;
            valid_q <= 1'b0;
            ovf     <= 1'b0;
            ptr     <= '0;
            cnt     <= '0;
        end else begin
            valid_q <= 1'b0;
            if (done) begin
                wait_q <= 1'b0;
            end
            if (xfer) begin
                if (s_beat.tlast) begin
                    wait_q  <= 1'b1;
                    valid_q <= 1'b1;
                    ovf     <= 1'b0;
                    ptr     <= '0;
                    cnt     <= '0;
                end else if (in_range) begin
                    ptr <= ptr + 1'b1;
                    cnt <= cnt + pkt_chk_pkg::blen_w'(pkt_chk_pkg::data_bytes);
                end else begin
                    ovf <= 1'b1;
                end
            end
        end
    end

    // packet payload, stable while the matcher searches
    always_ff @(posedge axis_packet_in) begin
        if (xfer && in_range) begin
            pkt_bytes[ptr*pkt_chk_pkg::data_bytes*8 +: pkt_chk_pkg::data_bytes*8] <= s_beat.tdata;
        end
        if (xfer && s_beat.tlast) begin
            pkt_blen <= in_range ? cnt + last_bytes : cnt;
            pkt_ovf  <= ovf || !in_range;
        end
    end

    assign pkt_valid    = valid_q;
    assign pkt.bytes    = pkt_bytes;
    assign pkt.blen     = pkt_blen;
    assign pkt.oversize = pkt_ovf;

    full_keep_mid_packet: assert property (@(posedge axis_packet_in) disable iff (rst)
        (xfer && !s_beat.tlast) |-> (s_beat.tkeep == '1));

    contiguous_keep_on_last: assert property (@(posedge axis_packet_in) disable iff (rst)
        (xfer && s_beat.tlast) |->
        (s_beat.tkeep[0] && $onehot({1'b0, s_beat.tkeep} + 5'd1)));

endmodule

/* source/pkt_chk_ctrl.sv */
// ####################
// wishbone slave with status counters, claimed mask and sticky error
// ####################
`timescale 1ns/10ps

module pkt_chk_ctrl (
    input  logic                                axis_packet_in,
    input  logic                                rst,
    input  pkt_chk_pkg::wb_req_t                wb_req,
    input  pkt_chk_pkg::match_result_t          result,
    input  pkt_chk_pkg::wb_word_u               store_rd_data,
    output pkt_chk_pkg::wb_rsp_t                wb_rsp,
    output pkt_chk_pkg::store_wr_t              store_wr,
    output logic                                store_clear,
    output logic [pkt_chk_pkg::slot_w-1:0]      store_rd_slot,
    output logic [pkt_chk_pkg::ofs_w-1:0]       store_rd_ofs,
    output logic [pkt_chk_pkg::num_slots-1:0]   claimed,
    output logic                                chk_error
);

    logic                                access;
    logic                                served;
    logic                                ack_q;
    logic [31:0]                         rd_q;
    logic [31:0]                         rd_mux;
    logic [pkt_chk_pkg::adr_w-1:0]       slot_adr;
    logic                                in_slots;
    logic                                ctrl_wr;
    logic [7:0]                          hit_cnt;
    logic [7:0]                          miss_cnt;
    logic [pkt_chk_pkg::num_slots-1:0]   claimed_q;
    logic                                error_q;

    // one access per strobe, served holds off a second ack
    assign access   = wb_req.cyc && wb_req.stb && !served;
    assign slot_adr = wb_req.adr - pkt_chk_pkg::adr_slot_base;
    assign in_slots = (wb_req.adr >= pkt_chk_pkg::adr_slot_base) &&
                      (slot_adr < pkt_chk_pkg::num_slots * 8);
    assign ctrl_wr  = access && wb_req.we && (wb_req.adr == pkt_chk_pkg::adr_ctrl);

    assign store_rd_slot     = slot_adr[pkt_chk_pkg::ofs_w +: pkt_chk_pkg::slot_w];
    assign store_rd_ofs      = slot_adr[pkt_chk_pkg::ofs_w-1:0];
    assign store_wr.we       = access && wb_req.we && in_slots;
    assign store_wr.slot     = store_rd_slot;
    assign store_wr.ofs      = store_rd_ofs;
    assign store_wr.word.raw = wb_req.dat;
    assign store_clear       = ctrl_wr && wb_req.dat[1];

    always_comb begin
        rd_mux = '0;
        if (wb_req.adr == pkt_chk_pkg::adr_status) begin
            // error bit 24, claimed 19:16, misses 15:8, hits 7:0
            rd_mux = {7'd0, error_q, 4'd0, claimed_q, miss_cnt, hit_cnt};
        end else if (in_slots) begin
            rd_mux = store_rd_data.raw;
        end
    end

    always_ff @(posedge axis_packet_in) begin
        if (rst) begin
            ack_q  <= 1'b0;
            served <= 1'b0;
        end else begin
            ack_q <= access;
            if (access) begin
                served <= 1'b1;
            end else if (!wb_req.stb) begin
                served <= 1'b0;
            end
        end
    end

    always_ff @(posedge axis_packet_in) begin
        if (access) begin
            rd_q <= rd_mux;
        end
    end

    always_ff @(posedge axis_packet_in) begin
        if (rst) begin
            hit_cnt   <= '0;
            miss_cnt  <= '0;
            claimed_q <= '0;
            error_q   <= 1'b0;
        end else if (ctrl_wr && wb_req.dat[0]) begin
            hit_cnt   <= '0;
            miss_cnt  <= '0;
            claimed_q <= '0;
            error_q   <= 1'b0;
        end else if (result.done) begin
            if (result.hit) begin
                hit_cnt                <= hit_cnt + 8'd1;
                claimed_q[result.slot] <= 1'b1;
            end else begin
                miss_cnt <= miss_cnt + 8'd1;
                error_q  <= 1'b1;
            end
        end
    end

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = rd_q;
    assign claimed    = claimed_q;
    assign chk_error  = error_q;

    ack_needs_strobe: assert property (@(posedge axis_packet_in) disable iff (rst)
        wb_rsp.ack |-> (wb_req.cyc && wb_req.stb));

endmodule

/* source/pkt_chk_pkg.sv */
// ####################
// packet checker sizes, bus words and datapath records
// ####################

package pkt_chk_pkg;

    localparam int data_bytes = 4;
    localparam int mtu_bytes  = 16;
    localparam int mtu_words  = mtu_bytes / data_bytes;
    localparam int num_slots  = 4;
    localparam int blen_w     = 5;
    localparam int slot_w     = 2;
    localparam int adr_w      = 6;
    // word offset in a slot window, data word index, beat pointer
    localparam int ofs_w      = 3;
    localparam int word_w     = 2;
    localparam int ptr_w      = 3;

    localparam logic [adr_w-1:0] adr_ctrl      = 6'd0;
    localparam logic [adr_w-1:0] adr_status    = 6'd1;
    // slot n lives at adr_slot_base + 8*n, descriptor first
    localparam logic [adr_w-1:0] adr_slot_base = 6'd16;

    typedef struct packed {
        logic [data_bytes*8-1:0] tdata;
        logic [data_bytes-1:0]   tkeep;
        logic                    tlast;
    } axis_beat_t;

    typedef struct packed {
        logic             cyc;
        logic             stb;
        logic             we;
        logic [adr_w-1:0] adr;
        logic [31:0]      dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // valid in bit 0, blen in bits 5:1
    typedef struct packed {
        logic [31-blen_w-1:0] rsvd;
        logic [blen_w-1:0]    blen;
        logic                 valid;
    } slot_desc_t;

    typedef union packed {
        logic [31:0] raw;
        slot_desc_t  desc;
    } wb_word_u;

    typedef struct packed {
        logic [mtu_bytes*8-1:0] bytes;
        logic [blen_w-1:0]      blen;
        logic                   oversize;
    } rx_pkt_t;

    typedef struct packed {
        logic              we;
        logic [slot_w-1:0] slot;
        logic [ofs_w-1:0]  ofs;
        wb_word_u          word;
    } store_wr_t;

    typedef struct packed {
        logic              done;
        logic              hit;
        logic [slot_w-1:0] slot;
    } match_result_t;

endpackage
